/* logic/rn_cfg.svh */
// ================================================
// Widths, sizes and node ids of the request node
// Included by the package and by every RTL module
// ================================================

`ifndef RN_CFG_SVH
`define RN_CFG_SVH

// Word address and one-word lines
`define RN_ADDR_W  16
`define RN_DATA_W  32

// Direct mapped store, 16 lines
`define RN_INDEX_W 4
`define RN_TAG_W   (`RN_ADDR_W - `RN_INDEX_W)

// Network ids
`define RN_TXN_W   8
`define RN_NODE_W  8
`define RN_NODE_ID 8'h05
`define RN_HOME_ID 8'h00

`endif

/* logic/rn_pkg.sv */
// ================================================
// Types of the request node: line states, opcodes,
// FSM states and the flit and port structs
// ================================================

`include "rn_cfg.svh"

package rn_pkg;

    typedef enum logic [1:0] {
        INVALID  = 2'd0,
        SHARED   = 2'd1,
        MODIFIED = 2'd3
    } line_state_e;

    typedef enum logic [1:0] {
        REQ_READ_SHARED,
        REQ_MAKE_UNIQUE,
        REQ_WRITE_BACK
    } req_op_e;

    typedef enum logic {RSP_COMP, RSP_COMP_DATA} rsp_op_e;

    typedef enum logic {SNP_SHARED, SNP_INVALIDATE} snp_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        SEND_WB,
        SEND_REQ,
        WAIT_RSP,
        WAIT_DAT,
        RESPOND
    } cpu_state_e;

    typedef enum logic [1:0] {SNP_IDLE, SNP_LOOKUP, SNP_RESPOND} snoop_state_e;

    // ================================================
    // CPU side
    // ================================================
    typedef struct packed {
        logic                  read;
        logic [`RN_ADDR_W-1:0] addr;
        logic [`RN_DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [`RN_TXN_W-1:0]  txn_id;
        logic [`RN_DATA_W-1:0] rdata;
    } cpu_rsp_t;

    // ================================================
    // Network flits
    // ================================================
    typedef struct packed {
        req_op_e               opcode;
        logic [`RN_ADDR_W-1:0] addr;
        logic [`RN_TXN_W-1:0]  txn_id;
        logic [`RN_NODE_W-1:0] src_id;
        logic [`RN_NODE_W-1:0] tgt_id;
        logic [`RN_DATA_W-1:0] data;
    } req_flit_t;

    typedef struct packed {
        rsp_op_e              opcode;
        logic [`RN_TXN_W-1:0] txn_id;
    } rsp_flit_t;

    typedef struct packed {
        logic [`RN_TXN_W-1:0]  txn_id;
        logic [`RN_DATA_W-1:0] data;
    } dat_flit_t;

    typedef struct packed {
        snp_op_e               opcode;
        logic [`RN_ADDR_W-1:0] addr;
        logic [`RN_TXN_W-1:0]  txn_id;
        logic [`RN_NODE_W-1:0] src_id;
    } snp_flit_t;

    // Resp carries the line state before the snoop
    typedef struct packed {
        logic                  has_data;
        line_state_e           resp;
        logic [`RN_TXN_W-1:0]  txn_id;
        logic [`RN_NODE_W-1:0] src_id;
        logic [`RN_NODE_W-1:0] tgt_id;
        logic [`RN_DATA_W-1:0] data;
    } snp_out_t;

    // ================================================
    // Line store ports
    // ================================================
    typedef struct packed {
        logic                  hit;
        line_state_e           state;
        logic [`RN_DATA_W-1:0] data;
    } line_rd_t;

    typedef struct packed {
        logic                   en;
        logic [`RN_INDEX_W-1:0] index;
        logic [`RN_TAG_W-1:0]   tag;
        line_state_e            state;
        logic [`RN_DATA_W-1:0]  data;
    } line_wr_t;

endpackage

/* logic/rn_line_store.sv */
// ================================================
// Direct mapped line store with a CPU port and a
// snoop port, both read combinationally
// ================================================

`timescale 1ns/1ps

`include "rn_cfg.svh"

module rn_line_store import rn_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`RN_INDEX_W-1:0] cpu_index,
    input  logic [`RN_TAG_W-1:0]   cpu_tag,
    input  line_wr_t               cpu_wr,
    output line_rd_t               cpu_rd,
    output logic [`RN_TAG_W-1:0]   victim_tag,
    input  logic [`RN_INDEX_W-1:0] snp_index,
    input  logic [`RN_TAG_W-1:0]   snp_tag,
    input  line_wr_t               snp_wr,
    output line_rd_t               snp_rd
);

    localparam int LINES = 1 << `RN_INDEX_W;

    logic [`RN_TAG_W-1:0]  tag_mem   [LINES];
    logic [`RN_DATA_W-1:0] data_mem  [LINES];
    line_state_e           state_mem [LINES];

    // On a miss the resident line is still reported, for write-back
    function automatic line_rd_t lookup(
        input logic [`RN_TAG_W-1:0]  line_tag,
        input line_state_e           line_state,
        input logic [`RN_DATA_W-1:0] line_data,
        input logic [`RN_TAG_W-1:0]  tag
    );
        line_rd_t rd;
        rd.hit   = (line_tag == tag) && (line_state != INVALID);
        rd.state = line_state;
        rd.data  = line_data;
        return rd;
    endfunction

    assign cpu_rd = lookup(tag_mem[cpu_index], state_mem[cpu_index],
                           data_mem[cpu_index], cpu_tag);
    assign snp_rd = lookup(tag_mem[snp_index], state_mem[snp_index],
                           data_mem[snp_index], snp_tag);

    assign victim_tag = tag_mem[cpu_index];

    // ================================================
    // Updates, snoop port last so it wins a collision
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                state_mem[i] <= INVALID;
            end
        end else begin
            if (cpu_wr.en) begin
                state_mem[cpu_wr.index] <= cpu_wr.state;
            end
            if (snp_wr.en) begin
                state_mem[snp_wr.index] <= snp_wr.state;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_wr.en) begin
            tag_mem[cpu_wr.index]  <= cpu_wr.tag;
            data_mem[cpu_wr.index] <= cpu_wr.data;
        end
        if (snp_wr.en) begin
            tag_mem[snp_wr.index]  <= snp_wr.tag;
            data_mem[snp_wr.index] <= snp_wr.data;
        end
    end

endmodule

/* logic/rn_cpu_ctrl.sv */
// ================================================
// CPU request FSM: local hits, write-back of dirty
// victims, requests to the home node and line fills
// ================================================

`timescale 1ns/1ps

`include "rn_cfg.svh"

module rn_cpu_ctrl import rn_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cpu_req_valid,
    input  cpu_req_t               cpu_req,
    output logic                   cpu_req_ready,
    output logic                   cpu_rsp_valid,
    input  logic                   cpu_rsp_ready,
    output cpu_rsp_t               cpu_rsp,
    output logic                   req_out_valid,
    input  logic                   req_out_ready,
    output req_flit_t              req_out,
    input  logic                   rsp_in_valid,
    input  rsp_flit_t              rsp_in,
    input  logic                   dat_in_valid,
    input  dat_flit_t              dat_in,
    output logic [`RN_INDEX_W-1:0] cpu_index,
    output logic [`RN_TAG_W-1:0]   cpu_tag,
    input  line_rd_t               cpu_rd,
    input  logic [`RN_TAG_W-1:0]   victim_tag,
    output line_wr_t               cpu_wr
);

    cpu_state_e            state;
    cpu_state_e            state_nxt;
    cpu_req_t              pend;
    logic [`RN_TXN_W-1:0]  txn_cnt;
    logic [`RN_TXN_W-1:0]  rsp_txn;
    logic [`RN_DATA_W-1:0] rdata;
    logic [`RN_ADDR_W-1:0] wb_addr;
    logic [`RN_DATA_W-1:0] wb_data;
    logic                  req_fire;
    logic                  rsp_match;
    logic                  dat_match;
    logic                  local_hit;

    assign req_fire  = req_out_valid && req_out_ready;
    assign rsp_match = rsp_in_valid && (rsp_in.txn_id == rsp_txn);
    assign dat_match = dat_in_valid && (dat_in.txn_id == rsp_txn);

    // Reads hit in any valid state, writes need ownership
    assign local_hit = cpu_rd.hit && (pend.read || cpu_rd.state == MODIFIED);

    assign cpu_index = pend.addr[`RN_INDEX_W-1:0];
    assign cpu_tag   = pend.addr[`RN_ADDR_W-1:`RN_INDEX_W];

    assign cpu_req_ready = (state == IDLE);
    assign cpu_rsp_valid = (state == RESPOND);
    assign cpu_rsp       = '{txn_id: rsp_txn, rdata: rdata};

    // ================================================
    // State machine
    // ================================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (cpu_req_valid) state_nxt = LOOKUP;
            end
            LOOKUP: begin
                if (local_hit) begin
                    state_nxt = RESPOND;
                end else if (cpu_rd.state == MODIFIED && victim_tag != cpu_tag) begin
                    state_nxt = SEND_WB;
                end else begin
                    state_nxt = SEND_REQ;
                end
            end
            SEND_WB: begin
                if (req_fire) state_nxt = SEND_REQ;
            end
            SEND_REQ: begin
                if (req_fire) state_nxt = WAIT_RSP;
            end
            WAIT_RSP: begin
                if (rsp_match) begin
                    state_nxt = (rsp_in.opcode == RSP_COMP_DATA) ? WAIT_DAT : RESPOND;
                end
            end
            WAIT_DAT: begin
                if (dat_match) state_nxt = RESPOND;
            end
            RESPOND: begin
                if (cpu_rsp_ready) state_nxt = IDLE;
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            txn_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Write-backs take an id too
            if (req_fire) txn_cnt <= txn_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_req_valid && cpu_req_ready) pend <= cpu_req;
        if (state == LOOKUP) begin
            wb_addr <= {victim_tag, cpu_index};
            wb_data <= cpu_rd.data;
            rdata   <= pend.read ? cpu_rd.data : pend.wdata;
            rsp_txn <= txn_cnt;
        end
        if (state == SEND_REQ && req_fire) rsp_txn <= txn_cnt;
        if (state == WAIT_DAT && dat_match && pend.read) rdata <= dat_in.data;
    end

    // ================================================
    // Line updates
    // ================================================
    always_comb begin
        cpu_wr       = '0;
        cpu_wr.index = cpu_index;
        cpu_wr.tag   = cpu_tag;
        case (state)
            LOOKUP: begin
                cpu_wr.en    = local_hit && !pend.read;
                cpu_wr.state = MODIFIED;
                cpu_wr.data  = pend.wdata;
            end
            SEND_WB: begin
                // Victim drops out once the home node has it
                cpu_wr.en    = req_fire;
                cpu_wr.state = INVALID;
            end
            WAIT_RSP: begin
                cpu_wr.en    = rsp_match && rsp_in.opcode == RSP_COMP && !pend.read;
                cpu_wr.state = MODIFIED;
                cpu_wr.data  = pend.wdata;
            end
            WAIT_DAT: begin
                cpu_wr.en    = dat_match;
                cpu_wr.state = pend.read ? SHARED : MODIFIED;
                cpu_wr.data  = pend.read ? dat_in.data : pend.wdata;
            end
            default: cpu_wr.en = 1'b0;
        endcase
    end

    // Request flit builder
    assign req_out_valid = (state == SEND_WB) || (state == SEND_REQ);

    always_comb begin
        req_out        = '0;
        req_out.txn_id = txn_cnt;
        req_out.src_id = `RN_NODE_ID;
        req_out.tgt_id = `RN_HOME_ID;
        if (state == SEND_WB) begin
            req_out.opcode = REQ_WRITE_BACK;
            req_out.addr   = wb_addr;
            req_out.data   = wb_data;
        end else begin
            req_out.opcode = pend.read ? REQ_READ_SHARED : REQ_MAKE_UNIQUE;
            req_out.addr   = pend.addr;
        end
    end

endmodule

/* logic/rn_snoop_ctrl.sv */
// ================================================
// Snoop engine: looks up the snooped line, changes
// its state and answers with completion or data
// ================================================

`timescale 1ns/1ps

`include "rn_cfg.svh"

module rn_snoop_ctrl import rn_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   snp_in_valid,
    input  snp_flit_t              snp_in,
    output logic                   snp_in_ready,
    output logic                   snp_out_valid,
    input  logic                   snp_out_ready,
    output snp_out_t               snp_out,
    output logic [`RN_INDEX_W-1:0] snp_index,
    output logic [`RN_TAG_W-1:0]   snp_tag,
    input  line_rd_t               snp_rd,
    output line_wr_t               snp_wr
);

    snoop_state_e state;
    snoop_state_e state_nxt;
    snp_flit_t    snp_q;
    line_state_e  prior;
    logic         dirty;

    assign snp_in_ready  = (state == SNP_IDLE);
    assign snp_out_valid = (state == SNP_RESPOND);

    assign snp_index = snp_q.addr[`RN_INDEX_W-1:0];
    assign snp_tag   = snp_q.addr[`RN_ADDR_W-1:`RN_INDEX_W];

    assign prior = snp_rd.hit ? snp_rd.state : INVALID;
    assign dirty = (prior == MODIFIED);

    always_comb begin
        state_nxt = state;
        case (state)
            SNP_IDLE: begin
                if (snp_in_valid) state_nxt = SNP_LOOKUP;
            end
            SNP_LOOKUP:  state_nxt = SNP_RESPOND;
            SNP_RESPOND: begin
                if (snp_out_ready) state_nxt = SNP_IDLE;
            end
            default: state_nxt = SNP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SNP_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Answer is built during lookup, held until taken
    always_ff @(posedge clk) begin
        if (snp_in_valid && snp_in_ready) snp_q <= snp_in;
        if (state == SNP_LOOKUP) begin
            snp_out <= '{has_data: dirty, resp: prior, txn_id: snp_q.txn_id,
                         src_id: `RN_NODE_ID, tgt_id: snp_q.src_id,
                         data: dirty ? snp_rd.data : '0};
        end
    end

    // SnpShared downgrades dirty lines, SnpInvalidate drops any hit
    always_comb begin
        snp_wr       = '0;
        snp_wr.index = snp_index;
        snp_wr.tag   = snp_tag;
        snp_wr.data  = snp_rd.data;
        if (state == SNP_LOOKUP && snp_rd.hit) begin
            if (snp_q.opcode == SNP_INVALIDATE) begin
                snp_wr.en    = 1'b1;
                snp_wr.state = INVALID;
            end else if (dirty) begin
                snp_wr.en    = 1'b1;
                snp_wr.state = SHARED;
            end
        end
    end

endmodule

/* logic/rn_node_top.sv */
// ================================================
// Coherent request node top: CPU controller, snoop
// engine and the shared line store
// ================================================

`timescale 1ns/1ps

`include "rn_cfg.svh"

module rn_node_top import rn_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_req_valid,
    input  cpu_req_t  cpu_req,
    output logic      cpu_req_ready,
    output logic      cpu_rsp_valid,
    input  logic      cpu_rsp_ready,
    output cpu_rsp_t  cpu_rsp,
    output logic      req_out_valid,
    input  logic      req_out_ready,
    output req_flit_t req_out,
    input  logic      rsp_in_valid,
    input  rsp_flit_t rsp_in,
    input  logic      dat_in_valid,
    input  dat_flit_t dat_in,
    input  logic      snp_in_valid,
    input  snp_flit_t snp_in,
    output logic      snp_in_ready,
    output logic      snp_out_valid,
    input  logic      snp_out_ready,
    output snp_out_t  snp_out
);

    logic [`RN_INDEX_W-1:0] cpu_index;
    logic [`RN_TAG_W-1:0]   cpu_tag;
    logic [`RN_TAG_W-1:0]   victim_tag;
    line_rd_t               cpu_rd;
    line_wr_t               cpu_wr;
    logic [`RN_INDEX_W-1:0] snp_index;
    logic [`RN_TAG_W-1:0]   snp_tag;
    line_rd_t               snp_rd;
    line_wr_t               snp_wr;

    rn_cpu_ctrl u_cpu_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_ready (cpu_rsp_ready),
        .cpu_rsp       (cpu_rsp),
        .req_out_valid (req_out_valid),
        .req_out_ready (req_out_ready),
        .req_out       (req_out),
        .rsp_in_valid  (rsp_in_valid),
        .rsp_in        (rsp_in),
        .dat_in_valid  (dat_in_valid),
        .dat_in        (dat_in),
        .cpu_index     (cpu_index),
        .cpu_tag       (cpu_tag),
        .cpu_rd        (cpu_rd),
        .victim_tag    (victim_tag),
        .cpu_wr        (cpu_wr)
    );

    rn_snoop_ctrl u_snoop_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .snp_in_valid  (snp_in_valid),
        .snp_in        (snp_in),
        .snp_in_ready  (snp_in_ready),
        .snp_out_valid (snp_out_valid),
        .snp_out_ready (snp_out_ready),
        .snp_out       (snp_out),
        .snp_index     (snp_index),
        .snp_tag       (snp_tag),
        .snp_rd        (snp_rd),
        .snp_wr        (snp_wr)
    );

    rn_line_store u_line_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_index  (cpu_index),
        .cpu_tag    (cpu_tag),
        .cpu_wr     (cpu_wr),
        .cpu_rd     (cpu_rd),
        .victim_tag (victim_tag),
        .snp_index  (snp_index),
        .snp_tag    (snp_tag),
        .snp_wr     (snp_wr),
        .snp_rd     (snp_rd)
    );

endmodule

/* tb/rn_home_model.svh */
// ================================================
// Home memory and expected line copies for the
// request node testbench, included in its module
// ================================================

`ifndef RN_HOME_MODEL_SVH
`define RN_HOME_MODEL_SVH

// Home memory, one word per address
logic [`RN_DATA_W-1:0] home_mem [1 << `RN_ADDR_W];

// Expected copy of each local line
line_state_e           exp_state [1 << `RN_INDEX_W];
logic [`RN_TAG_W-1:0]  exp_tag   [1 << `RN_INDEX_W];
logic [`RN_DATA_W-1:0] exp_data  [1 << `RN_INDEX_W];

// Request flits expected for the current CPU access
req_flit_t             exp_flits [$];
logic [`RN_TXN_W-1:0]  exp_txn;

function automatic logic [`RN_DATA_W-1:0] fill_word(input logic [`RN_ADDR_W-1:0] addr);
    return {~addr, addr ^ 16'h5a3c};
endfunction

task automatic home_init();
    for (int a = 0; a < (1 << `RN_ADDR_W); a++) begin
        home_mem[a] = fill_word(16'(a));
    end
    for (int i = 0; i < (1 << `RN_INDEX_W); i++) begin
        exp_state[i] = INVALID;
    end
    exp_txn = '0;
endtask

// Each accepted request flit takes the next id
function automatic void push_flit(input req_op_e op, input logic [`RN_ADDR_W-1:0] addr,
                                  input logic [`RN_DATA_W-1:0] data);
    req_flit_t f;
    f.opcode = op;
    f.addr   = addr;
    f.txn_id = exp_txn;
    f.src_id = `RN_NODE_ID;
    f.tgt_id = `RN_HOME_ID;
    f.data   = data;
    exp_flits.push_back(f);
    exp_txn++;
endfunction

// ================================================
// CPU access: expected flits, line update, rdata
// ================================================
function automatic void model_cpu(input logic read, input logic [`RN_ADDR_W-1:0] addr,
                                  input logic [`RN_DATA_W-1:0] wdata,
                                  output logic [`RN_DATA_W-1:0] rdata,
                                  output logic local_hit);
    logic [`RN_INDEX_W-1:0] idx;
    logic [`RN_TAG_W-1:0]   tag;
    logic                   hit;
    idx = addr[`RN_INDEX_W-1:0];
    tag = addr[`RN_ADDR_W-1:`RN_INDEX_W];
    hit = (exp_state[idx] != INVALID) && (exp_tag[idx] == tag);
    local_hit = hit && (read || exp_state[idx] == MODIFIED);
    if (!local_hit) begin
        // Dirty victim of another tag goes home first
        if (exp_state[idx] == MODIFIED && exp_tag[idx] != tag) begin
            push_flit(REQ_WRITE_BACK, {exp_tag[idx], idx}, exp_data[idx]);
        end
        push_flit(read ? REQ_READ_SHARED : REQ_MAKE_UNIQUE, addr, '0);
    end
    if (read) begin
        if (!local_hit) begin
            exp_data[idx]  = home_mem[addr];
            exp_state[idx] = SHARED;
        end
        rdata = exp_data[idx];
    end else begin
        exp_data[idx]  = wdata;
        exp_state[idx] = MODIFIED;
        rdata          = wdata;
    end
    exp_tag[idx] = tag;
endfunction

// Snoop: expected answer from the prior state
function automatic snp_out_t model_snoop(input snp_flit_t s);
    snp_out_t               o;
    logic [`RN_INDEX_W-1:0] idx;
    logic                   hit;
    idx = s.addr[`RN_INDEX_W-1:0];
    hit = (exp_state[idx] != INVALID) &&
          (exp_tag[idx] == s.addr[`RN_ADDR_W-1:`RN_INDEX_W]);
    o.resp     = hit ? exp_state[idx] : INVALID;
    o.has_data = (o.resp == MODIFIED);
    o.txn_id   = s.txn_id;
    o.src_id   = `RN_NODE_ID;
    o.tgt_id   = s.src_id;
    o.data     = o.has_data ? exp_data[idx] : '0;
    if (hit && s.opcode == SNP_INVALIDATE) begin
        exp_state[idx] = INVALID;
    end else if (o.has_data) begin
        exp_state[idx] = SHARED;
    end
    return o;
endfunction

`endif

/* tb/tb_rn_node.sv */
// ================================================
// Testbench of the request node: random CPU and
// snoop traffic, home responder and model checks
// ================================================

`timescale 1ns/1ps

`include "rn_cfg.svh"

module tb_rn_node import rn_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic      clk;
    logic      rst_n;
    logic      cpu_req_valid;
    cpu_req_t  cpu_req;
    logic      cpu_req_ready;
    logic      cpu_rsp_valid;
    logic      cpu_rsp_ready;
    cpu_rsp_t  cpu_rsp;
    logic      req_out_valid;
    logic      req_out_ready;
    req_flit_t req_out;
    logic      rsp_in_valid;
    rsp_flit_t rsp_in;
    logic      dat_in_valid;
    dat_flit_t dat_in;
    logic      snp_in_valid;
    snp_flit_t snp_in;
    logic      snp_in_ready;
    logic      snp_out_valid;
    logic      snp_out_ready;
    snp_out_t  snp_out;
    integer    seed;

    `include "rn_home_model.svh"

    rn_node_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp_ready (cpu_rsp_ready),
        .cpu_rsp       (cpu_rsp),
        .req_out_valid (req_out_valid),
        .req_out_ready (req_out_ready),
        .req_out       (req_out),
        .rsp_in_valid  (rsp_in_valid),
        .rsp_in        (rsp_in),
        .dat_in_valid  (dat_in_valid),
        .dat_in        (dat_in),
        .snp_in_valid  (snp_in_valid),
        .snp_in        (snp_in),
        .snp_in_ready  (snp_in_ready),
        .snp_out_valid (snp_out_valid),
        .snp_out_ready (snp_out_ready),
        .snp_out       (snp_out)
    );

    always #4 clk = ~clk;

    // Inputs change and outputs are read 1 ns after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic fail_stop(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("error at %0t: %s, got %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // ================================================
    // One CPU access with the home node answering
    // ================================================
    task automatic cpu_access(input logic read, input logic [`RN_ADDR_W-1:0] addr,
                              input logic [`RN_DATA_W-1:0] wdata);
        logic [`RN_DATA_W-1:0] exp_rdata;
        logic [`RN_TXN_W-1:0]  exp_rsp_txn;
        logic [`RN_TXN_W-1:0]  home_txn;
        logic [`RN_ADDR_W-1:0] home_addr;
        logic                  home_read;
        logic                  local_hit;
        logic                  done;
        req_flit_t             got;
        req_flit_t             exp_f;
        int                    n;
        int                    rsp_wait;
        int                    dat_wait;
        model_cpu(read, addr, wdata, exp_rdata, local_hit);
        cpu_req_valid = 1'b1;
        cpu_req       = '{read: read, addr: addr, wdata: wdata};
        n = 0;
        while (!cpu_req_ready) begin
            step();
            n++;
            if (n > TIMEOUT) fail_stop("timeout waiting for the node to take a CPU request");
        end
        step();
        cpu_req_valid = 1'b0;
        n        = 0;
        done     = 1'b0;
        rsp_wait = 0;
        dat_wait = 0;
        while (!done) begin
            rsp_in_valid = 1'b0;
            dat_in_valid = 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    rsp_in_valid  = 1'b1;
                    rsp_in.opcode = home_read ? RSP_COMP_DATA : RSP_COMP;
                    rsp_in.txn_id = home_txn;
                    if (home_read) dat_wait = 1 + ($random(seed) & 3);
                end
            end else if (dat_wait > 0) begin
                dat_wait--;
                if (dat_wait == 0) begin
                    dat_in_valid  = 1'b1;
                    dat_in.txn_id = home_txn;
                    dat_in.data   = home_mem[home_addr];
                end
            end
            req_out_ready = $random(seed) & 1;
            if (req_out_valid && req_out_ready) begin
                got = req_out;
                if (exp_flits.size() == 0) fail_stop("the node sent a request flit not expected");
                exp_f = exp_flits.pop_front();
                check(got, exp_f, "request flit");
                if (exp_f.opcode == REQ_WRITE_BACK) begin
                    home_mem[got.addr] = got.data;
                end else begin
                    home_read   = (got.opcode == REQ_READ_SHARED);
                    home_addr   = got.addr;
                    home_txn    = got.txn_id;
                    exp_rsp_txn = exp_f.txn_id;
                    rsp_wait    = 1 + ($random(seed) & 3);
                end
            end
            if (cpu_rsp_valid) begin
                if (local_hit) begin
                    check(n + 1, 2, "hit response latency");
                end else begin
                    check(cpu_rsp.txn_id, exp_rsp_txn, "CPU response txn_id");
                end
                check(cpu_rsp.rdata, exp_rdata, "CPU response data");
                done = 1'b1;
            end
            step();
            n++;
            if (n > TIMEOUT) fail_stop("timeout waiting for the CPU response");
        end
        check(exp_flits.size(), 0, "request flits still expected");
    endtask

    // Snoop with random back-pressure on the answer
    task automatic snoop(input snp_op_e op, input logic [`RN_ADDR_W-1:0] addr);
        snp_flit_t s;
        snp_out_t  exp;
        logic      seen;
        logic      done;
        int        n;
        s.opcode = op;
        s.addr   = addr;
        s.txn_id = $random(seed);
        s.src_id = $random(seed);
        exp      = model_snoop(s);
        snp_in_valid = 1'b1;
        snp_in       = s;
        n = 0;
        while (!snp_in_ready) begin
            step();
            n++;
            if (n > TIMEOUT) fail_stop("timeout waiting for the node to take a snoop");
        end
        step();
        snp_in_valid = 1'b0;
        n    = 0;
        seen = 1'b0;
        done = 1'b0;
        while (!done) begin
            snp_out_ready = $random(seed) & 1;
            if (snp_out_valid) begin
                if (!seen) check(n + 1, 2, "snoop answer latency");
                seen = 1'b1;
                if (snp_out_ready) begin
                    check(snp_out, exp, "snoop answer");
                    done = 1'b1;
                end
            end
            step();
            n++;
            if (n > TIMEOUT) fail_stop("timeout waiting for the snoop answer");
        end
    endtask

    // ================================================
    // Reset, directed cases, then random traffic
    // ================================================
    initial begin
        logic [`RN_ADDR_W-1:0] addr;
        int                    kind;
        seed          = 32'h4a;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        req_out_ready = 1'b0;
        rsp_in_valid  = 1'b0;
        rsp_in        = '0;
        dat_in_valid  = 1'b0;
        dat_in        = '0;
        snp_in_valid  = 1'b0;
        snp_in        = '0;
        snp_out_ready = 1'b0;
        home_init();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check(cpu_req_ready, 1, "cpu_req_ready after reset");
        check(snp_in_ready, 1, "snp_in_ready after reset");
        check({cpu_rsp_valid, req_out_valid, snp_out_valid}, 0, "valids after reset");
        cpu_rsp_ready = 1'b1;

        cpu_access(1'b0, 16'h0013, 32'hdead_beef);
        cpu_access(1'b1, 16'h0013, '0);
        snoop(SNP_SHARED, 16'h0013);
        cpu_access(1'b0, 16'h0013, 32'h1234_5678);
        // Same index, other tag, dirty victim
        cpu_access(1'b0, 16'h0023, 32'h0bad_f00d);
        snoop(SNP_INVALIDATE, 16'h0023);
        cpu_access(1'b1, 16'h0023, '0);
        cpu_access(1'b1, 16'h0013, '0);
        snoop(SNP_SHARED, 16'h0044);

        // Small address pool: 4 lines, 4 tags each
        for (int i = 0; i < 400; i++) begin
            addr = 16'($random(seed)) & 16'h0033;
            kind = $random(seed) & 7;
            if (kind < 2) begin
                snoop(kind[0] ? SNP_INVALIDATE : SNP_SHARED, addr);
            end else begin
                cpu_access(kind[0], addr, $random(seed));
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
+incdir+tb
logic/rn_pkg.sv
logic/rn_line_store.sv
logic/rn_cpu_ctrl.sv
logic/rn_snoop_ctrl.sv
logic/rn_node_top.sv
tb/tb_rn_node.sv
